// File: rtl/clint_pkg.sv
package clint_pkg;

    // hart count and index width
    localparam int NUM_HARTS = 2;
    localparam int HART_W    = 1;

    // only the low ADDR_W address bits are decoded
    localparam int ADDR_W = 16;
    localparam int DATA_W = 64;
    localparam int STRB_W = 8;

    // register map
    localparam logic [ADDR_W-1:0] MSIP_BASE     = 16'h0000;
    localparam logic [ADDR_W-1:0] MTIMECMP_BASE = 16'h4000;
    localparam logic [ADDR_W-1:0] MTIME_ADDR    = 16'hBFF8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_MSIP,
        SEL_MTIMECMP,
        SEL_MTIME
    } reg_sel_e;

    // master side of the AXI-lite port
    typedef struct packed {
        logic              aw_valid;
        logic [63:0]       aw_addr;
        logic              w_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              b_ready;
        logic              ar_valid;
        logic [63:0]       ar_addr;
        logic              r_ready;
    } axi_req_t;

    // slave side of the AXI-lite port
    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axi_rsp_t;

    // decoded single-cycle register write
    typedef struct packed {
        logic              valid;
        reg_sel_e          sel;
        logic [HART_W-1:0] hart;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } reg_wr_t;

    typedef struct packed {
        logic [63:0] mtimecmp;
        logic        msip;
    } hart_rd_t;

    // strobed bytes take the new data, the others keep the old value
    function automatic logic [DATA_W-1:0] byte_merge(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int i = 0; i < STRB_W; i++)
        begin
            if (strb[i])
            begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: rtl/clint_mtime.sv
`timescale 1ns/1ps

module clint_mtime (
    input  logic               clk,
    input  logic               rst_n,
    input  clint_pkg::reg_wr_t reg_wr,
    output logic [63:0]        mtime
);

    logic [63:0] mtime_q;
    logic        wr_hit;

    assign wr_hit = reg_wr.valid && (reg_wr.sel == clint_pkg::SEL_MTIME);

    // a write replaces the increment for that cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtime_q <= '0;
        end
        else if (wr_hit)
        begin
            mtime_q <= clint_pkg::byte_merge(mtime_q, reg_wr.wdata, reg_wr.wstrb);
        end
        else
        begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    assign mtime = mtime_q;

endmodule

// File: rtl/clint_hart_timer.sv
`timescale 1ns/1ps

module clint_hart_timer #(
    parameter int HART_ID = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  clint_pkg::reg_wr_t  reg_wr,
    input  logic [63:0]         mtime,
    output clint_pkg::hart_rd_t hart_rd,
    output logic                mtip,
    output logic                msip
);

    logic [63:0] mtimecmp_q;
    logic        msip_q;
    logic        mtip_q;
    logic        hart_hit;

    assign hart_hit = reg_wr.valid && (reg_wr.hart == HART_ID[clint_pkg::HART_W-1:0]);

    // all-ones compare value keeps the timer quiet after reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
            mtip_q     <= 1'b0;
        end
        else
        begin
            if (hart_hit && reg_wr.sel == clint_pkg::SEL_MTIMECMP)
            begin
                mtimecmp_q <= clint_pkg::byte_merge(mtimecmp_q, reg_wr.wdata,
                                                    reg_wr.wstrb);
            end
            // only bit 0 of msip is implemented
            if (hart_hit && reg_wr.sel == clint_pkg::SEL_MSIP && reg_wr.wstrb[0])
            begin
                msip_q <= reg_wr.wdata[0];
            end
            // level interrupt lags the compare by one cycle
            mtip_q <= (mtime >= mtimecmp_q);
        end
    end

    always_comb
    begin
        hart_rd.mtimecmp = mtimecmp_q;
        hart_rd.msip     = msip_q;
    end

    assign mtip = mtip_q;
    assign msip = msip_q;

endmodule

// File: rtl/clint_axi_slave.sv
`timescale 1ns/1ps

module clint_axi_slave (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  clint_pkg::axi_req_t                         bus_req,
    output clint_pkg::axi_rsp_t                         bus_rsp,
    output clint_pkg::reg_wr_t                          reg_wr,
    input  logic [63:0]                                 mtime,
    input  clint_pkg::hart_rd_t [clint_pkg::NUM_HARTS-1:0] hart_rd
);

    // write channel state
    logic                              wr_rdy_q;
    logic                              wr_vld_q;
    logic                              b_valid_q;
    logic [1:0]                        b_resp_q;

    // read channel state
    logic                              rd_rdy_q;
    logic                              rd_pend_q;
    logic                              r_valid_q;
    logic [1:0]                        r_resp_q;
    logic [clint_pkg::DATA_W-1:0]      r_data_q;

    clint_pkg::reg_sel_e               aw_sel;
    clint_pkg::reg_sel_e               ar_sel;
    logic [clint_pkg::HART_W-1:0]      aw_hart;
    logic [clint_pkg::HART_W-1:0]      ar_hart;
    logic                              wr_idle;
    logic                              wr_fire;
    logic                              rd_idle;
    logic                              rd_fire;
    logic [clint_pkg::DATA_W-1:0]      rd_mux;

    // msip and mtimecmp each have one 8-byte slot per hart
    function automatic clint_pkg::reg_sel_e decode_sel(
        input logic [clint_pkg::ADDR_W-1:0] addr
    );
        logic [clint_pkg::ADDR_W-1:0] msip_off;
        logic [clint_pkg::ADDR_W-1:0] cmp_off;
        msip_off   = addr - clint_pkg::MSIP_BASE;
        cmp_off    = addr - clint_pkg::MTIMECMP_BASE;
        decode_sel = clint_pkg::SEL_NONE;
        if (addr == clint_pkg::MTIME_ADDR)
        begin
            decode_sel = clint_pkg::SEL_MTIME;
        end
        else if (addr[2:0] == 3'b000 &&
                 32'(msip_off[clint_pkg::ADDR_W-1:3]) < clint_pkg::NUM_HARTS)
        begin
            decode_sel = clint_pkg::SEL_MSIP;
        end
        else if (addr[2:0] == 3'b000 &&
                 32'(cmp_off[clint_pkg::ADDR_W-1:3]) < clint_pkg::NUM_HARTS)
        begin
            decode_sel = clint_pkg::SEL_MTIMECMP;
        end
    endfunction

    assign aw_sel  = decode_sel(bus_req.aw_addr[clint_pkg::ADDR_W-1:0]);
    assign ar_sel  = decode_sel(bus_req.ar_addr[clint_pkg::ADDR_W-1:0]);
    // both bases are 8-byte aligned so the hart index sits at bit 3
    assign aw_hart = bus_req.aw_addr[3 +: clint_pkg::HART_W];
    assign ar_hart = bus_req.ar_addr[3 +: clint_pkg::HART_W];

    // one write in flight from the ready pulse until b is taken
    assign wr_idle = !wr_rdy_q && !wr_vld_q && !b_valid_q;
    assign wr_fire = wr_rdy_q && bus_req.aw_valid && bus_req.w_valid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_rdy_q  <= 1'b0;
            wr_vld_q  <= 1'b0;
            b_valid_q <= 1'b0;
        end
        else
        begin
            wr_rdy_q <= wr_idle && bus_req.aw_valid && bus_req.w_valid;
            wr_vld_q <= wr_fire;
            if (wr_vld_q)
            begin
                b_valid_q <= 1'b1;
            end
            else if (b_valid_q && bus_req.b_ready)
            begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
        begin
            b_resp_q <= (aw_sel == clint_pkg::SEL_NONE) ? clint_pkg::RESP_SLVERR
                                                         : clint_pkg::RESP_OKAY;
        end
    end

    // read side mirrors the write side
    assign rd_idle = !rd_rdy_q && !rd_pend_q && !r_valid_q;
    assign rd_fire = rd_rdy_q && bus_req.ar_valid;

    always_comb
    begin
        case (ar_sel)
            clint_pkg::SEL_MTIME:    rd_mux = mtime;
            clint_pkg::SEL_MTIMECMP: rd_mux = hart_rd[ar_hart].mtimecmp;
            clint_pkg::SEL_MSIP:     rd_mux = {63'b0, hart_rd[ar_hart].msip};
            default:                 rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_rdy_q  <= 1'b0;
            rd_pend_q <= 1'b0;
            r_valid_q <= 1'b0;
        end
        else
        begin
            rd_rdy_q  <= rd_idle && bus_req.ar_valid;
            rd_pend_q <= rd_fire;
            if (rd_pend_q)
            begin
                r_valid_q <= 1'b1;
            end
            else if (r_valid_q && bus_req.r_ready)
            begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // data is sampled at the address handshake and held until taken
    always_ff @(posedge clk)
    begin
        if (rd_fire)
        begin
            r_data_q <= rd_mux;
            r_resp_q <= (ar_sel == clint_pkg::SEL_NONE) ? clint_pkg::RESP_SLVERR
                                                         : clint_pkg::RESP_OKAY;
        end
    end

    // registers take the write on the handshake edge itself
    always_comb
    begin
        reg_wr.valid = wr_fire;
        reg_wr.sel   = aw_sel;
        reg_wr.hart  = aw_hart;
        reg_wr.wdata = bus_req.w_data;
        reg_wr.wstrb = bus_req.w_strb;
    end

    always_comb
    begin
        bus_rsp.aw_ready = wr_rdy_q;
        bus_rsp.w_ready  = wr_rdy_q;
        bus_rsp.b_valid  = b_valid_q;
        bus_rsp.b_resp   = b_resp_q;
        bus_rsp.ar_ready = rd_rdy_q;
        bus_rsp.r_valid  = r_valid_q;
        bus_rsp.r_data   = r_data_q;
        bus_rsp.r_resp   = r_resp_q;
    end

endmodule

// File: rtl/clint_top.sv
`timescale 1ns/1ps

module clint_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  clint_pkg::axi_req_t            bus_req,
    output clint_pkg::axi_rsp_t            bus_rsp,
    output logic [clint_pkg::NUM_HARTS-1:0] mtip,
    output logic [clint_pkg::NUM_HARTS-1:0] msip
);

    clint_pkg::reg_wr_t                             reg_wr;
    logic [63:0]                                    mtime;
    clint_pkg::hart_rd_t [clint_pkg::NUM_HARTS-1:0] hart_rd;

    // bus decode and response generation
    clint_axi_slave u_slave (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .reg_wr  (reg_wr),
        .mtime   (mtime),
        .hart_rd (hart_rd)
    );

    // shared real-time counter
    clint_mtime u_mtime (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .mtime  (mtime)
    );

    // one compare and msip block per hart
    for (genvar h = 0; h < clint_pkg::NUM_HARTS; h++)
    begin : g_hart
        clint_hart_timer #(
            .HART_ID (h)
        ) u_hart_timer (
            .clk     (clk),
            .rst_n   (rst_n),
            .reg_wr  (reg_wr),
            .mtime   (mtime),
            .hart_rd (hart_rd[h]),
            .mtip    (mtip[h]),
            .msip    (msip[h])
        );
    end

endmodule

// File: verif/clint_assert.sv
`timescale 1ns/1ps

module clint_assert (
    input logic                clk,
    input logic                rst_n,
    input clint_pkg::axi_req_t bus_req,
    input clint_pkg::axi_rsp_t bus_rsp
);

    int fail_count = 0;

    // write response stays put until the master takes it
    property b_held;
        @(posedge clk) disable iff (!rst_n)
        bus_rsp.b_valid && !bus_req.b_ready |=> bus_rsp.b_valid && $stable(bus_rsp.b_resp);
    endproperty

    property r_held;
        @(posedge clk) disable iff (!rst_n)
        bus_rsp.r_valid && !bus_req.r_ready |=>
            bus_rsp.r_valid && $stable(bus_rsp.r_data) && $stable(bus_rsp.r_resp);
    endproperty

    // address and data of a write are accepted together
    property aw_with_w;
        @(posedge clk) disable iff (!rst_n)
        bus_rsp.aw_ready |-> bus_rsp.w_ready && bus_req.aw_valid && bus_req.w_valid;
    endproperty

    b_held_check: assert property (b_held)
    else
    begin
        fail_count++;
        $error("b_valid or b_resp changed before b_ready");
    end

    r_held_check: assert property (r_held)
    else
    begin
        fail_count++;
        $error("r_valid, r_data or r_resp changed before r_ready");
    end

    aw_with_w_check: assert property (aw_with_w)
    else
    begin
        fail_count++;
        $error("aw_ready was high without w_ready or without both valids");
    end

endmodule

bind clint_axi_slave clint_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
);

// File: verif/clint_tb.sv
`timescale 1ns/1ps

module clint_tb;

    localparam int CLK_PERIOD = 100;
    localparam int MAX_TESTS  = 64;
    localparam int NAME_W     = 8 * 24;

    logic                            clk;
    logic                            rst_n;
    clint_pkg::axi_req_t             bus_req;
    clint_pkg::axi_rsp_t             bus_rsp;
    logic [clint_pkg::NUM_HARTS-1:0] mtip;
    logic [clint_pkg::NUM_HARTS-1:0] msip;

    // one entry per line of the stimulus file
    logic [NAME_W-1:0] t_name [MAX_TESTS];
    logic [7:0]        t_op   [MAX_TESTS];
    logic [63:0]       t_addr [MAX_TESTS];
    logic [63:0]       t_data [MAX_TESTS];
    logic [7:0]        t_strb [MAX_TESTS];
    logic [63:0]       t_exp  [MAX_TESTS];
    logic [1:0]        t_resp [MAX_TESTS];

    int num_tests    = 0;
    int error_count  = 0;
    int pass_count   = 0;
    int fail_count   = 0;
    bit tests_loaded = 1'b0;

    clint_top uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .mtip    (mtip),
        .msip    (msip)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_tests();
        int                fd;
        int                code;
        logic [NAME_W-1:0] tok;
        logic [8*128-1:0]  rest;
        fd = $fopen("verif/clint_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open verif/clint_input.txt");
            return;
        end
        while (num_tests < MAX_TESTS)
        begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
            begin
                break;
            end
            // lines whose first word is a lone hash are comments
            if (tok == {{(NAME_W - 8){1'b0}}, 8'h23})
            begin
                code = $fgets(rest, fd);
            end
            else
            begin
                t_name[num_tests] = tok;
                code = $fscanf(fd, "%s %h %h %h %h %h", t_op[num_tests], t_addr[num_tests],
                               t_data[num_tests], t_strb[num_tests], t_exp[num_tests],
                               t_resp[num_tests]);
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input logic [NAME_W-1:0] name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act)
        begin
            $display("MISMATCH %0s %0s: expected %h, actual %h", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic report_error(input logic [NAME_W-1:0] name, input string msg);
        $display("ERROR %0s: %0s", name, msg);
        error_count++;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, output logic [1:0] resp);
        int delay;
        @(negedge clk);
        bus_req.aw_valid = 1'b1;
        bus_req.aw_addr  = addr;
        bus_req.w_valid  = 1'b1;
        bus_req.w_data   = data;
        bus_req.w_strb   = strb;
        @(negedge clk);
        while (!(bus_rsp.aw_ready && bus_rsp.w_ready))
            @(negedge clk);
        // the transfer happens on the rising edge in between
        @(negedge clk);
        bus_req.aw_valid = 1'b0;
        bus_req.w_valid  = 1'b0;
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        bus_req.b_ready = 1'b1;
        while (!bus_rsp.b_valid)
            @(negedge clk);
        resp = bus_rsp.b_resp;
        @(negedge clk);
        bus_req.b_ready = 1'b0;
    endtask

    task automatic bus_read(input logic [63:0] addr, output logic [63:0] data,
                            output logic [1:0] resp);
        int delay;
        @(negedge clk);
        bus_req.ar_valid = 1'b1;
        bus_req.ar_addr  = addr;
        @(negedge clk);
        while (!bus_rsp.ar_ready)
            @(negedge clk);
        @(negedge clk);
        bus_req.ar_valid = 1'b0;
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        bus_req.r_ready = 1'b1;
        while (!bus_rsp.r_valid)
            @(negedge clk);
        data = bus_rsp.r_data;
        resp = bus_rsp.r_resp;
        @(negedge clk);
        bus_req.r_ready = 1'b0;
    endtask

    task automatic run_test(input int i);
        logic [1:0]  resp;
        logic [63:0] rdata;
        logic [63:0] first;
        int          hart;
        int          cycles;
        case (t_op[i])
            "W":
            begin
                // expected data holds the msip vector after the write
                bus_write(t_addr[i], t_data[i], t_strb[i], resp);
                check_value(t_name[i], "resp", 64'(t_resp[i]), 64'(resp));
                check_value(t_name[i], "msip", t_exp[i], 64'(msip));
            end
            "R":
            begin
                bus_read(t_addr[i], rdata, resp);
                check_value(t_name[i], "rdata", t_exp[i], rdata);
                check_value(t_name[i], "resp", 64'(t_resp[i]), 64'(resp));
            end
            "M":
            begin
                bus_write(t_addr[i], t_data[i], t_strb[i], resp);
                check_value(t_name[i], "write resp", 64'(t_resp[i]), 64'(resp));
                bus_read(t_addr[i], first, resp);
                check_value(t_name[i], "read resp", 64'(t_resp[i]), 64'(resp));
                if (first <= t_data[i] || first >= t_data[i] + 64'd40)
                begin
                    report_error(t_name[i], $sformatf("mtime read %h is outside %h+1 .. %h+39",
                                                      first, t_data[i], t_data[i]));
                end
                bus_read(t_addr[i], rdata, resp);
                check_value(t_name[i], "second read resp", 64'(t_resp[i]), 64'(resp));
                if (rdata <= first)
                begin
                    report_error(t_name[i], "second mtime read did not increase");
                end
            end
            "T":
            begin
                hart = int'((t_addr[i][15:0] - clint_pkg::MTIMECMP_BASE) >> 3);
                // compare value goes first so the old mtime cannot trip it
                bus_write(t_addr[i], t_data[i] + 64'd30, 8'hff, resp);
                check_value(t_name[i], "mtimecmp resp", 64'(t_resp[i]), 64'(resp));
                bus_write(64'(clint_pkg::MTIME_ADDR), t_data[i], 8'hff, resp);
                check_value(t_name[i], "mtime resp", 64'(t_resp[i]), 64'(resp));
                check_value(t_name[i], "mtip after setup", 64'd0, 64'(mtip));
                cycles = 0;
                while (!mtip[hart] && cycles < 60)
                begin
                    @(negedge clk);
                    cycles++;
                end
                check_value(t_name[i], "mtip raised", t_exp[i], 64'(mtip));
                bus_write(t_addr[i], '1, 8'hff, resp);
                check_value(t_name[i], "restore resp", 64'(t_resp[i]), 64'(resp));
                cycles = 0;
                while (mtip[hart] && cycles < 3)
                begin
                    @(negedge clk);
                    cycles++;
                end
                check_value(t_name[i], "mtip cleared", 64'd0, 64'(mtip));
            end
            default:
            begin
                report_error(t_name[i], "unknown operation code in the stimulus file");
            end
        endcase
    endtask

    initial
    begin
        int errors_before;
        int assert_errors;
        bus_req    = '0;
        rst_n      = 1'b0;
        void'($urandom(5));
        load_tests();
        tests_loaded = 1'b1;
        if (num_tests == 0)
        begin
            report_error("load", "no tests were read from the stimulus file");
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < num_tests; i++)
        begin
            errors_before = error_count;
            run_test(i);
            if (error_count == errors_before)
            begin
                pass_count++;
                $display("PASS %0s", t_name[i]);
            end
            else
            begin
                fail_count++;
                $display("FAIL %0s", t_name[i]);
            end
        end
        assert_errors = uut.u_slave.u_assert.fail_count;
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_count, fail_count, assert_errors);
        if (error_count == 0 && assert_errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

    // budget of 60 cycles per test on top of reset and setup
    initial
    begin
        wait (tests_loaded);
        repeat (num_tests * 60 + 200) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles",
                 num_tests * 60 + 200);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: verif/clint_input.txt
# name op addr data strb exp_data exp_resp, all numbers in hex
# exp_data is the msip vector for W, read data for R, the fired mtip vector for T
cmp0_full        W 4000 1122334455667788 ff 0                0
cmp0_full_rd     R 4000 0                00 1122334455667788 0
cmp0_part        W 4000 aabbccddeeff0011 0f 0                0
cmp0_part_rd     R 4000 0                00 11223344eeff0011 0
cmp1_full        W 4008 0102030405060708 ff 0                0
cmp1_full_rd     R 4008 0                00 0102030405060708 0
cmp1_part        W 4008 f0e0d0c0b0a09080 a5 0                0
cmp1_part_rd     R 4008 0                00 f002d00405a00780 0
msip0_set        W 0000 1                ff 1                0
msip1_set        W 0008 ffffffffffffffff ff 3                0
msip1_rd         R 0008 0                00 1                0
msip0_clr        W 0000 fffffffffffffffe ff 2                0
msip0_rd         R 0000 0                00 0                0
msip1_clr        W 0008 0                ff 0                0
bad_wr_cmp2      W 4010 deadbeefdeadbeef ff 0                2
bad_wr_msip2     W 0010 1                ff 0                2
bad_wr_misalign  W 4004 0                ff 0                2
bad_chk_cmp0     R 4000 0                00 11223344eeff0011 0
bad_chk_cmp1     R 4008 0                00 f002d00405a00780 0
bad_rd           R 1234 0                00 0                2
mtime_low        M bff8 10000            ff 0                0
mtime_carry      M bff8 fffffffc         ff 0                0
timer_hart0      T 4000 200000000        ff 1                0
timer_hart1      T 4008 300000000        ff 2                0

// File: all.f
rtl/clint_pkg.sv
rtl/clint_mtime.sv
rtl/clint_hart_timer.sv
rtl/clint_axi_slave.sv
rtl/clint_top.sv
verif/clint_assert.sv
verif/clint_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
